/* source/video_pkg.sv */
package video_pkg;

	// dram word address, 2M words
	typedef logic [20:0] video_addr_t;

	// tile-map page base, upper address byte
	typedef logic [7:0] page_t;

	// scroll offset in pixels
	// same width for xs and ys
	typedef logic [8:0] scroll_t;

	// outstanding request credits
	// limits up to 15
	typedef logic [3:0] credit_t;

	// video mode
	typedef enum logic
	{
		// classic pixel + attribute screen
		VM_ZX,
		// tile-map entries, one or two planes
		VM_TILE
	} video_mode_t;

	// request port fsm
	typedef enum logic [1:0]
	{
		// nothing fetched since reset
		FS_IDLE,
		// issuing the words of the current line
		FS_LINE,
		// line count reached, wait for next line
		FS_DONE
	} fetch_state_t;

endpackage

/* source/video_sync.sv */
`timescale 1ns/10ps

module video_sync #(
	parameter int H_TOTAL        = 448,
	parameter int V_TOTAL        = 320,
	parameter int V_ACTIVE_START = 64,
	parameter int V_ACTIVE_LINES = 192
) (
	input  logic clk,
	input  logic rst_n,
	output logic int_start,
	output logic line_start,
	output logic yctr_init,
	output logic vpix
);

	localparam int HW = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;
	localparam int VW = (V_TOTAL > 1) ? $clog2(V_TOTAL) : 1;

	// raster position
	logic [HW-1:0] hctr;
	logic [HW-1:0] hctr_nxt;
	logic [VW-1:0] vctr;
	logic [VW-1:0] vctr_nxt;
	logic          h_wrap;
	logic          v_wrap;

	// next raster position
	always_comb
	begin
		h_wrap   = (hctr == HW'(H_TOTAL - 1));
		v_wrap   = (vctr == VW'(V_TOTAL - 1));
		hctr_nxt = h_wrap ? '0 : hctr + 1'b1;
		vctr_nxt = vctr;
		if (h_wrap)
		begin
			// line wraps, step to next line or back to line 0
			vctr_nxt = v_wrap ? '0 : vctr + 1'b1;
		end
	end

	// counters start at the last clock of the frame
	// so the first clock after reset opens line 0
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hctr <= HW'(H_TOTAL - 1);
			vctr <= VW'(V_TOTAL - 1);
		end
		else
		begin
			hctr <= hctr_nxt;
			vctr <= vctr_nxt;
		end
	end

	// decoded events, registered so they line up with the counters
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_start  <= 1'b0;
			line_start <= 1'b0;
			yctr_init  <= 1'b0;
			vpix       <= 1'b0;
		end
		else
		begin
			// first clock of every line
			line_start <= h_wrap;
			// first clock of line 0
			int_start  <= h_wrap && (vctr_nxt == '0);
			// first clock of the first active line
			yctr_init  <= h_wrap && (vctr_nxt == VW'(V_ACTIVE_START));
			// whole active lines
			vpix       <= (vctr_nxt >= VW'(V_ACTIVE_START)) &&
				(vctr_nxt < V_ACTIVE_START + V_ACTIVE_LINES);
		end
	end

endmodule

/* source/video_addrgen.sv */
`timescale 1ns/10ps

module video_addrgen (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    int_start,
	input  logic                    fetch_start,
	input  logic                    yctr_init,
	input  logic                    line_start,
	input  logic                    video_next,
	input  video_pkg::video_mode_t  mode,
	input  logic                    scr_page,
	input  video_pkg::page_t        tp,
	input  video_pkg::scroll_t      xs,
	input  video_pkg::scroll_t      ys,
	input  logic                    tp1en,
	output video_pkg::video_addr_t  video_addr,
	output logic                    addr_valid
);

	// zx counter
	// [0] attr or pix, [4:1] word in line, [12:5] screen line
	logic [12:0] zxctr;
	logic [12:0] zx_nxt;

	// tile counters
	// xctr: [0] plane, [6:1] column before scroll
	// yctr: [2:0] line in tile, [8:3] row before scroll
	logic [7:0]  xctr;
	logic [7:0]  x_nxt;
	logic [8:0]  yctr;

	// first load of the line, one clock after fetch_start
	logic        fetch_start_r;
	logic        ld_addr;

	logic [11:0] zx_pix;
	logic [11:0] zx_attr;
	logic [5:0]  tile_row;
	logic [5:0]  tile_col;

	video_pkg::video_addr_t addr_zx;
	video_pkg::video_addr_t addr_tile;
	video_pkg::video_addr_t addr_sel;

	// counters as they stand after this clock
	// the address register loads from these
	assign zx_nxt = video_next ? zxctr + 13'd1 : zxctr;
	// without plane 1 the count skips bit 0
	assign x_nxt  = video_next ? xctr + (tp1en ? 8'd1 : 8'd2) : xctr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			zxctr <= '0;
		else if (int_start)
			zxctr <= '0;
		else
			zxctr <= zx_nxt;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			xctr <= '0;
		else if (fetch_start)
			xctr <= '0;
		else
			xctr <= x_nxt;
	end

	// y counter only moves on lines that fetch
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			yctr <= '0;
		else if (line_start)
		begin
			if (yctr_init)
				yctr <= '0;
			else if (fetch_start)
				yctr <= yctr + 9'd1;
		end
	end

	// zx pixel word, third / char line / row swap
	assign zx_pix  = {zx_nxt[12:11], zx_nxt[7:5], zx_nxt[10:8], zx_nxt[4:1]};
	// attribute word from the character row
	assign zx_attr = {3'b110, zx_nxt[12:8], zx_nxt[4:1]};
	// fixed screen prefix and page bit
	assign addr_zx = {6'b000001, scr_page, 2'b10, (zx_nxt[0] ? zx_attr : zx_pix)};

	// scroll adds at tile granularity, 6 bit sums wrap mod 64
	assign tile_row  = yctr[8:3] + ys[8:3];
	assign tile_col  = x_nxt[6:1] + xs[8:3];
	// page 8, row 6, column 6, plane 1
	assign addr_tile = {tp, tile_row, tile_col, x_nxt[0]};

	assign addr_sel = (mode == video_pkg::VM_ZX) ? addr_zx : addr_tile;
	assign ld_addr  = video_next || fetch_start_r;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fetch_start_r <= 1'b0;
			addr_valid    <= 1'b0;
		end
		else
		begin
			fetch_start_r <= fetch_start;
			// invalid while the first word of the new line loads
			if (fetch_start)
				addr_valid <= 1'b0;
			else if (fetch_start_r)
				addr_valid <= 1'b1;
		end
	end

	// address register
	always_ff @(posedge clk)
	begin
		if (ld_addr)
			video_addr <= addr_sel;
	end

endmodule

/* source/fetch_req_port.sv */
`timescale 1ns/10ps

module fetch_req_port #(
	parameter int CREDITS = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    line_start,
	input  logic                    vpix,
	input  video_pkg::video_mode_t  mode,
	input  logic                    tp1en,
	input  logic                    credit_ret,
	input  logic                    addr_valid,
	input  video_pkg::video_addr_t  video_addr,
	output logic                    fetch_start,
	output logic                    video_next,
	output logic                    req_valid,
	output video_pkg::video_addr_t  req_addr
);

	video_pkg::fetch_state_t state;
	video_pkg::credit_t      credits;

	// requests issued in this line, up to 64
	logic [6:0] req_cnt;
	logic [6:0] req_limit;
	logic       issue;
	logic       last_req;

	// every active line starts a fetch
	assign fetch_start = line_start && vpix;

	// two planes in tile mode double the word count
	assign req_limit = (mode == video_pkg::VM_TILE && tp1en) ? 7'd64 : 7'd32;

	// no issue while a new line restarts the address generator
	assign issue = (state == video_pkg::FS_LINE) && addr_valid &&
		(credits != '0) && !fetch_start;
	assign last_req = issue && (req_cnt == req_limit - 7'd1);

	assign req_valid  = issue;
	assign video_next = issue;
	assign req_addr   = video_addr;

	// line fsm and request count
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= video_pkg::FS_IDLE;
			req_cnt <= '0;
		end
		else if (fetch_start)
		begin
			// count restarts even if the last line stalled
			state   <= video_pkg::FS_LINE;
			req_cnt <= '0;
		end
		else if (last_req)
		begin
			state   <= video_pkg::FS_DONE;
			req_cnt <= '0;
		end
		else if (issue)
			req_cnt <= req_cnt + 7'd1;
	end

	// credit counter
	// request and return in the same clock cancel out
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= video_pkg::credit_t'(CREDITS);
		else if (issue && !credit_ret)
			credits <= credits - 1'b1;
		else if (credit_ret && !issue)
			credits <= credits + 1'b1;
	end

endmodule

/* source/video_fetch_top.sv */
`timescale 1ns/10ps

module video_fetch_top #(
	parameter int H_TOTAL        = 448,
	parameter int V_TOTAL        = 320,
	parameter int V_ACTIVE_START = 64,
	parameter int V_ACTIVE_LINES = 192,
	parameter int CREDITS        = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  video_pkg::video_mode_t  mode,
	input  logic                    scr_page,
	input  video_pkg::page_t        tp,
	input  video_pkg::scroll_t      xs,
	input  video_pkg::scroll_t      ys,
	input  logic                    tp1en,
	input  logic                    credit_ret,
	output logic                    req_valid,
	output video_pkg::video_addr_t  req_addr
);

	// raster events
	logic int_start;
	logic line_start;
	logic yctr_init;
	logic vpix;

	// address generator handshake
	logic                   fetch_start;
	logic                   video_next;
	logic                   addr_valid;
	video_pkg::video_addr_t video_addr;

	video_sync #(
		.H_TOTAL        (H_TOTAL),
		.V_TOTAL        (V_TOTAL),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_LINES (V_ACTIVE_LINES)
	) u_sync (.clk, .rst_n, .int_start, .line_start, .yctr_init, .vpix);

	video_addrgen u_addrgen (
		.clk, .rst_n, .int_start, .fetch_start, .yctr_init, .line_start, .video_next,
		.mode, .scr_page, .tp, .xs, .ys, .tp1en,
		.video_addr, .addr_valid
	);

	fetch_req_port #(
		.CREDITS (CREDITS)
	) u_req_port (
		.clk, .rst_n, .line_start, .vpix, .mode, .tp1en, .credit_ret,
		.addr_valid, .video_addr,
		.fetch_start, .video_next, .req_valid, .req_addr
	);

endmodule

/* bench/video_fetch_properties.sv */
`timescale 1ns/10ps

module video_fetch_properties #(
	parameter int CREDITS = 4
) (
	input logic                    clk,
	input logic                    rst_n,
	input video_pkg::fetch_state_t state,
	input logic                    req_valid,
	input logic                    video_next,
	input logic                    credit_ret
);

	// number of failed checks
	int fail_count = 0;

	// requests held by the dram side
	int outstanding;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(req_valid) - int'(credit_ret);
	end

	// never more in flight than the dram side can hold
	a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding >= 0 && outstanding <= CREDITS)
	else
	begin
		$error("outstanding requests %0d out of range", outstanding);
		fail_count = fail_count + 1;
	end

	// requests only while a line is being fetched
	a_req_in_line: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> state == video_pkg::FS_LINE)
	else
	begin
		$error("request outside FS_LINE");
		fail_count = fail_count + 1;
	end

	// address advance and request are the same event
	a_next_is_req: assert property (@(posedge clk) disable iff (!rst_n)
		video_next == req_valid)
	else
	begin
		$error("video_next differs from req_valid");
		fail_count = fail_count + 1;
	end

endmodule

// checks ride along with every request port
bind fetch_req_port video_fetch_properties #(
	.CREDITS (CREDITS)
) u_props (
	.clk, .rst_n, .state, .req_valid, .video_next, .credit_ret
);

/* bench/video_fetch_tb.sv */
`timescale 1ns/10ps

module video_fetch_tb;

	// short frames, long enough lines for slow credits
	localparam int H_TOTAL        = 256;
	localparam int V_TOTAL        = 14;
	localparam int V_ACTIVE_START = 3;
	localparam int V_ACTIVE_LINES = 10;
	localparam int CREDITS        = 4;
	localparam int FRAME_LIMIT    = H_TOTAL * V_TOTAL + 16;

	logic                   clk;
	logic                   rst_n;
	video_pkg::video_mode_t mode;
	logic                   scr_page;
	video_pkg::page_t       tp;
	video_pkg::scroll_t     xs;
	video_pkg::scroll_t     ys;
	logic                   tp1en;
	logic                   credit_ret;
	logic                   req_valid;
	video_pkg::video_addr_t req_addr;

	// dram model
	logic        slow_credits;
	logic [31:0] rng;
	int          cyc;
	int          due_q[$];

	// line tracking
	string test_name;
	int    line_idx;
	int    act_line;
	logic  line_open;
	int    line_cnt;
	int    line_exp;
	int    value_errors;
	int    protocol_errors;
	int    timeouts;
	logic  aborted;

	video_fetch_top #(
		.H_TOTAL        (H_TOTAL),
		.V_TOTAL        (V_TOTAL),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_LINES (V_ACTIVE_LINES),
		.CREDITS        (CREDITS)
	) UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected word address for request idx of active line
	function automatic video_pkg::video_addr_t expected_addr(input video_pkg::video_mode_t m,
		input logic page, input video_pkg::page_t tpv, input video_pkg::scroll_t xsv,
		input video_pkg::scroll_t ysv, input logic two_planes, input int line, input int idx);
		int a;
		int x;
		int row;
		int col;
		if (m == video_pkg::VM_ZX)
		begin
			// screen at 0xa000, second page 0x4000 up
			a = 'hA000 + (page ? 'h4000 : 0) + (idx / 2) % 16;
			if (idx % 2 == 1)
				// attribute area, one row per 8 lines
				a = a + 'hC00 + ((line / 8) % 32) * 16;
			else
				// third, pixel line in char, char row
				a = a + ((line / 64) % 4) * 1024 + (line % 8) * 128 + ((line / 8) % 8) * 16;
		end
		else
		begin
			// one plane steps the column every request
			x   = two_planes ? idx : 2 * idx;
			col = ((x / 2) % 64 + int'(xsv) / 8) % 64;
			row = ((line / 8) % 64 + int'(ysv) / 8) % 64;
			a   = int'(tpv) * 8192 + row * 128 + col * 2 + x % 2;
		end
		return video_pkg::video_addr_t'(a);
	endfunction

	task automatic check_addr(input string name, input video_pkg::video_addr_t exp,
		input video_pkg::video_addr_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("[ERROR] %s: req_addr expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			value_errors++;
			$display("[ERROR] %s: requests per line expected %0d, got %0d", name, exp, act);
		end
	endtask

	// credits come back in order, one per clock at most
	always @(posedge clk)
	begin
		cyc++;
		if (rst_n && req_valid)
		begin
			rng = xorshift32(rng);
			due_q.push_back(cyc + (slow_credits ? 8 + int'(rng % 32'd12) : 1 + int'(rng % 32'd8)));
		end
		if (due_q.size() > 0 && due_q[0] <= cyc)
		begin
			credit_ret <= 1'b1;
			void'(due_q.pop_front());
		end
		else
			credit_ret <= 1'b0;
	end

	// compare process, mid-cycle sampling
	always @(negedge clk)
	begin
		if (rst_n && UUT.line_start)
		begin
			if (line_open)
				check_count(test_name, line_exp, line_cnt);
			line_open = 1'b0;
			if (UUT.int_start)
				line_idx = 0;
			else if (line_idx >= 0)
				line_idx++;
			act_line = line_idx - V_ACTIVE_START;
			if (line_idx >= V_ACTIVE_START && act_line < V_ACTIVE_LINES)
			begin
				line_open = 1'b1;
				line_cnt  = 0;
				line_exp  = (mode == video_pkg::VM_TILE && tp1en) ? 64 : 32;
			end
		end
		if (rst_n && req_valid)
		begin
			if (!line_open)
			begin
				protocol_errors++;
				$display("request outside an active line, line %0d address %h", line_idx, req_addr);
			end
			else
			begin
				check_addr(test_name, expected_addr(mode, scr_page, tp, xs, ys, tp1en,
					act_line, line_cnt), req_addr);
				line_cnt++;
			end
		end
	end

	task automatic wait_frame_start();
		int n;
		n = 0;
		@(negedge clk);
		while (UUT.int_start !== 1'b1 && n < FRAME_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (UUT.int_start !== 1'b1)
		begin
			timeouts++;
			aborted = 1'b1;
			$display("no frame start seen within %0d cycles", FRAME_LIMIT);
		end
	endtask

	// set up during line 0, then run one whole frame
	task automatic run_frame(input string name, input video_pkg::video_mode_t m,
		input logic page, input video_pkg::page_t tpv, input video_pkg::scroll_t xsv,
		input video_pkg::scroll_t ysv, input logic two_planes, input logic slow);
		if (!aborted)
		begin
			@(posedge clk);
			test_name = name;
			mode         <= m;
			scr_page     <= page;
			tp           <= tpv;
			xs           <= xsv;
			ys           <= ysv;
			tp1en        <= two_planes;
			slow_credits <= slow;
			wait_frame_start();
		end
	endtask

	initial
	begin
		int assert_errors;
		rst_n = 1'b0;
		mode = video_pkg::VM_ZX;
		scr_page = 1'b0;
		tp = '0;
		xs = '0;
		ys = '0;
		tp1en = 1'b0;
		credit_ret = 1'b0;
		slow_credits = 1'b0;
		rng = 32'hd0a80400;
		cyc = 0;
		test_name = "reset";
		line_idx = -1;
		line_open = 1'b0;
		value_errors = 0;
		protocol_errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait_frame_start();
		run_frame("zx_page0", video_pkg::VM_ZX, 1'b0, 8'h00, 9'h000, 9'h000, 1'b0, 1'b0);
		run_frame("zx_page1", video_pkg::VM_ZX, 1'b1, 8'h00, 9'h000, 9'h000, 1'b0, 1'b0);
		// scroll sums wrap past 63 in both axes
		run_frame("tile_two_planes", video_pkg::VM_TILE, 1'b0, 8'hA5, 9'h1D7, 9'h1FC, 1'b1, 1'b0);
		run_frame("tile_one_plane", video_pkg::VM_TILE, 1'b0, 8'h3C, 9'h0F5, 9'h10B, 1'b0, 1'b0);
		// back to zx with slow credits, zx counter must restart
		run_frame("zx_backpressure", video_pkg::VM_ZX, 1'b1, 8'h00, 9'h000, 9'h000, 1'b0, 1'b1);
		assert_errors = UUT.u_req_port.u_props.fail_count;
		$display("errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
			value_errors, protocol_errors, timeouts, assert_errors);
		if (value_errors + protocol_errors + timeouts + assert_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* video_fetch.f */
source/video_pkg.sv
source/video_sync.sv
source/video_addrgen.sv
source/fetch_req_port.sv
source/video_fetch_top.sv
bench/video_fetch_properties.sv
bench/video_fetch_tb.sv

/* Bender.yml */
package:
  name: video_fetch

sources:
  - files:
      - source/video_pkg.sv
      - source/video_sync.sv
      - source/video_addrgen.sv
      - source/fetch_req_port.sv
      - source/video_fetch_top.sv
  - target: test
    files:
      - bench/video_fetch_properties.sv
      - bench/video_fetch_tb.sv
